//--- design/bank_port_if.sv
`timescale 1ns/1ps

// router <-> bank sequencer, one per sram bank
interface bank_port_if;
    import soc_bus_pkg::*;

    mem_req_t inst_slot;   // fetch request aimed at this bank
    mem_req_t data_slot;   // load/store request aimed at this bank
    word_t    inst_rdata;  // held until the next request starts
    word_t    data_rdata;
    logic     busy;        // bank still working on its slots

    modport router (
        output inst_slot,
        output data_slot,
        input  inst_rdata,
        input  data_rdata,
        input  busy
    );

    modport sequencer (
        input  inst_slot,
        input  data_slot,
        output inst_rdata,
        output data_rdata,
        output busy
    );

endinterface

//--- design/bank_sequencer.sv
`timescale 1ns/1ps

module bank_sequencer (
    input  logic           clk_cpu,
    input  logic           locked_i,  // async reset, active low
    bank_port_if.sequencer port,
    sram_cmd_if.seq        cmd
);
    import soc_bus_pkg::*;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_inst = 2'd1,  // fetch access running
        st_data = 2'd2,  // load/store access running
        st_done = 2'd3   // one quiet cycle, cpu releases its request
    } state_e;

    state_e   state_q;
    logic     issue_q;       // data access still to be started
    logic     any_slot;
    logic     start_now;
    mem_req_t inst_q;        // both slots latched on leaving idle
    mem_req_t data_q;
    mem_req_t cur_req;       // request the phy works on
    word_t    inst_rdata_q;
    word_t    data_rdata_q;

    assign any_slot  = port.inst_slot.valid | port.data_slot.valid;
    assign start_now = (state_q == st_idle) & any_slot;

    // first access goes out straight from the port, fetch first
    always_comb begin
        case (state_q)
            st_idle: cur_req = port.inst_slot.valid ? port.inst_slot : port.data_slot;
            st_inst: cur_req = inst_q;
            default: cur_req = data_q;
        endcase
    end

    assign cmd.start = start_now | issue_q;
    assign cmd.we    = cur_req.we;
    assign cmd.addr  = cur_req.addr;
    assign cmd.wdata = cur_req.wdata;
    assign cmd.mask  = cur_req.mask;

    // busy from the very cycle a slot shows up
    assign port.busy = start_now | (state_q == st_inst) | (state_q == st_data);

    always_ff @(posedge clk_cpu or negedge locked_i) begin
        if (!locked_i) begin
            state_q <= st_idle;
            issue_q <= 1'b0;
        end else begin
            issue_q <= 1'b0;  // start is a single pulse
            case (state_q)
                st_idle: begin
                    if (port.inst_slot.valid)
                        state_q <= st_inst;
                    else if (port.data_slot.valid)
                        state_q <= st_data;  // data already started
                end
                st_inst: begin
                    if (cmd.done) begin
                        state_q <= data_q.valid ? st_data : st_done;
                        issue_q <= data_q.valid;  // same bank, data goes second
                    end
                end
                st_data: if (cmd.done) state_q <= st_done;
                default: state_q <= st_idle;
            endcase
        end
    end

    // request and return payloads
    always_ff @(posedge clk_cpu) begin
        if (start_now) begin
            inst_q <= port.inst_slot;
            data_q <= port.data_slot;
        end
        if (cmd.done) begin
            if (state_q == st_inst)
                inst_rdata_q <= cmd.rdata;
            else
                data_rdata_q <= cmd.rdata;
        end
    end

    assign port.inst_rdata = inst_rdata_q;
    assign port.data_rdata = data_rdata_q;

endmodule

//--- design/bus_router.sv
`timescale 1ns/1ps

module bus_router (
    input  logic               clk_cpu,
    input  logic               locked_i,      // async reset, active low
    input  logic               inst_re_i,     // fetch strobe
    input  soc_bus_pkg::addr_t inst_addr_i,
    output soc_bus_pkg::word_t inst_data_o,
    input  logic               data_re_i,
    input  logic               data_we_i,
    input  soc_bus_pkg::addr_t data_addr_i,
    input  soc_bus_pkg::word_t data_wdata_i,
    input  soc_bus_pkg::mask_t data_mask_i,
    output soc_bus_pkg::word_t data_rdata_o,
    output logic               stall_o,       // cpu holds its levels while high
    bank_port_if.router        base_port,
    bank_port_if.router        ext_port
);
    import soc_bus_pkg::*;

    bank_e    inst_bank;    // live decode, none when strobe low
    bank_e    data_bank;
    bank_e    inst_bank_q;  // last bank each port hit
    bank_e    data_bank_q;
    bank_e    inst_sel;     // bank the return word comes from
    bank_e    data_sel;
    mem_req_t inst_req;
    mem_req_t data_req;
    logic     data_act;
    logic     base_held;    // bank holds at least one slot
    logic     ext_held;

    // top bits of the address pick the window
    function automatic bank_e decode_bank(input addr_t a);
        if ((a >> BANK_WINDOW_BITS) == (BASE_RAM_BASE >> BANK_WINDOW_BITS))
            return bank_base;
        if ((a >> BANK_WINDOW_BITS) == (EXT_RAM_BASE >> BANK_WINDOW_BITS))
            return bank_ext;
        return bank_none;  // outside both windows
    endfunction

    function automatic word_t pick_word(input bank_e sel, input word_t base_w,
                                        input word_t ext_w);
        case (sel)
            bank_base: return base_w;
            bank_ext:  return ext_w;
            default:   return '0;  // unmapped reads as zero
        endcase
    endfunction

    assign data_act  = data_re_i | data_we_i;
    assign inst_bank = inst_re_i ? decode_bank(inst_addr_i) : bank_none;
    assign data_bank = data_act ? decode_bank(data_addr_i) : bank_none;

    // request payloads, steered below
    always_comb begin
        inst_req       = '0;
        inst_req.valid = 1'b1;
        inst_req.we    = 1'b0;  // fetch never writes
        inst_req.addr  = inst_addr_i[BANK_WINDOW_BITS-1:2];
        inst_req.mask  = FULL_MASK;

        data_req       = '0;
        data_req.valid = 1'b1;
        data_req.we    = data_we_i;
        data_req.addr  = data_addr_i[BANK_WINDOW_BITS-1:2];
        data_req.wdata = data_wdata_i;
        data_req.mask  = data_mask_i;
    end

    assign base_port.inst_slot = (inst_bank == bank_base) ? inst_req : '0;
    assign base_port.data_slot = (data_bank == bank_base) ? data_req : '0;
    assign ext_port.inst_slot  = (inst_bank == bank_ext) ? inst_req : '0;
    assign ext_port.data_slot  = (data_bank == bank_ext) ? data_req : '0;

    assign base_held = (inst_bank == bank_base) | (data_bank == bank_base);
    assign ext_held  = (inst_bank == bank_ext) | (data_bank == bank_ext);
    assign stall_o   = (base_held & base_port.busy) | (ext_held & ext_port.busy);

    // remember the hit so the word stays routed once the strobe drops
    always_ff @(posedge clk_cpu or negedge locked_i) begin
        if (!locked_i) begin
            inst_bank_q <= bank_none;
            data_bank_q <= bank_none;
        end else begin
            if (inst_re_i)
                inst_bank_q <= inst_bank;
            if (data_act)
                data_bank_q <= data_bank;
        end
    end

    assign inst_sel = inst_re_i ? inst_bank : inst_bank_q;
    assign data_sel = data_act ? data_bank : data_bank_q;

    assign inst_data_o  = pick_word(inst_sel, base_port.inst_rdata, ext_port.inst_rdata);
    assign data_rdata_o = pick_word(data_sel, base_port.data_rdata, ext_port.data_rdata);

endmodule

//--- design/soc_bus_pkg.sv
package soc_bus_pkg;

    // basic bus words
    typedef logic [31:0] word_t;      // one data word
    typedef logic [31:0] addr_t;      // cpu byte address
    typedef logic [3:0]  mask_t;      // byte lanes, active high
    typedef logic [19:0] ram_addr_t;  // sram word index, byte addr [21:2]

    // where a request lands
    typedef enum logic [1:0] {
        bank_none = 2'd0,  // unmapped or no strobe
        bank_base = 2'd1,
        bank_ext  = 2'd2
    } bank_e;

    // one request as handed to a bank, 58 bits
    typedef struct packed {
        logic      valid;  // slot holds a request
        logic      we;     // write when set, read otherwise
        ram_addr_t addr;
        word_t     wdata;
        mask_t     mask;   // lanes to write
    } mem_req_t;

    // address map, two 4 MiB windows back to back
    localparam addr_t BASE_RAM_BASE    = 32'h8000_0000;
    localparam addr_t EXT_RAM_BASE     = 32'h8040_0000;
    localparam int    BANK_WINDOW_BITS = 22;  // byte width of one window

    // instruction fetch always reads the full word
    localparam mask_t FULL_MASK = 4'b1111;

    // cycles per sram access, must be 2 or more
    localparam int ACCESS_CYCLES_DEFAULT = 2;

endpackage

//--- design/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top #(
    parameter int ACCESS_CYCLES = soc_bus_pkg::ACCESS_CYCLES_DEFAULT
) (
    input  logic                   clk_cpu,
    input  logic                   locked_i,         // async reset, active low
    // cpu side
    input  logic                   inst_re_i,
    input  soc_bus_pkg::addr_t     inst_addr_i,
    output soc_bus_pkg::word_t     inst_data_o,
    input  logic                   data_re_i,
    input  logic                   data_we_i,
    input  soc_bus_pkg::addr_t     data_addr_i,
    input  soc_bus_pkg::word_t     data_wdata_i,
    input  soc_bus_pkg::mask_t     data_mask_i,
    output soc_bus_pkg::word_t     data_rdata_o,
    output logic                   stall_o,
    // base sram
    output soc_bus_pkg::ram_addr_t base_ram_addr_o,
    input  soc_bus_pkg::word_t     base_ram_data_i,
    output soc_bus_pkg::word_t     base_ram_data_o,
    output logic                   base_ram_data_oe_o,
    output soc_bus_pkg::mask_t     base_ram_be_n_o,
    output logic                   base_ram_ce_n_o,
    output logic                   base_ram_oe_n_o,
    output logic                   base_ram_we_n_o,
    // ext sram
    output soc_bus_pkg::ram_addr_t ext_ram_addr_o,
    input  soc_bus_pkg::word_t     ext_ram_data_i,
    output soc_bus_pkg::word_t     ext_ram_data_o,
    output logic                   ext_ram_data_oe_o,
    output soc_bus_pkg::mask_t     ext_ram_be_n_o,
    output logic                   ext_ram_ce_n_o,
    output logic                   ext_ram_oe_n_o,
    output logic                   ext_ram_we_n_o
);

    bank_port_if base_port ();
    bank_port_if ext_port ();
    sram_cmd_if  base_cmd ();
    sram_cmd_if  ext_cmd ();

    bus_router u_router (
        .clk_cpu, .locked_i,
        .inst_re_i, .inst_addr_i, .inst_data_o,
        .data_re_i, .data_we_i, .data_addr_i, .data_wdata_i, .data_mask_i,
        .data_rdata_o, .stall_o,
        .base_port (base_port),
        .ext_port  (ext_port)
    );

    bank_sequencer u_base_seq (.clk_cpu, .locked_i, .port(base_port), .cmd(base_cmd));
    bank_sequencer u_ext_seq  (.clk_cpu, .locked_i, .port(ext_port), .cmd(ext_cmd));

    sram_phy #(.ACCESS_CYCLES(ACCESS_CYCLES)) u_base_phy (
        .clk_cpu, .locked_i, .cmd(base_cmd),
        .ram_addr_o(base_ram_addr_o), .ram_data_i(base_ram_data_i),
        .ram_data_o(base_ram_data_o), .ram_data_oe_o(base_ram_data_oe_o),
        .ram_be_n_o(base_ram_be_n_o), .ram_ce_n_o(base_ram_ce_n_o),
        .ram_oe_n_o(base_ram_oe_n_o), .ram_we_n_o(base_ram_we_n_o)
    );

    sram_phy #(.ACCESS_CYCLES(ACCESS_CYCLES)) u_ext_phy (
        .clk_cpu, .locked_i, .cmd(ext_cmd),
        .ram_addr_o(ext_ram_addr_o), .ram_data_i(ext_ram_data_i),
        .ram_data_o(ext_ram_data_o), .ram_data_oe_o(ext_ram_data_oe_o),
        .ram_be_n_o(ext_ram_be_n_o), .ram_ce_n_o(ext_ram_ce_n_o),
        .ram_oe_n_o(ext_ram_oe_n_o), .ram_we_n_o(ext_ram_we_n_o)
    );

endmodule

//--- design/sram_cmd_if.sv
`timescale 1ns/1ps

// one access at a time from sequencer to pin driver
interface sram_cmd_if;
    import soc_bus_pkg::*;

    logic      start;  // one cycle, only while the phy is idle
    logic      we;
    ram_addr_t addr;
    word_t     wdata;
    mask_t     mask;
    word_t     rdata;  // valid together with done
    logic      done;   // last cycle of the access

    modport seq (
        output start,
        output we,
        output addr,
        output wdata,
        output mask,
        input  rdata,
        input  done
    );

    modport phy (
        input  start,
        input  we,
        input  addr,
        input  wdata,
        input  mask,
        output rdata,
        output done
    );

endinterface

//--- design/sram_phy.sv
`timescale 1ns/1ps

module sram_phy #(
    parameter int ACCESS_CYCLES = soc_bus_pkg::ACCESS_CYCLES_DEFAULT  // 2 or more
) (
    input  logic                   clk_cpu,
    input  logic                   locked_i,       // async reset, active low
    sram_cmd_if.phy                cmd,
    output soc_bus_pkg::ram_addr_t ram_addr_o,
    input  soc_bus_pkg::word_t     ram_data_i,
    output soc_bus_pkg::word_t     ram_data_o,
    output logic                   ram_data_oe_o,  // we drive the data pins
    output soc_bus_pkg::mask_t     ram_be_n_o,
    output logic                   ram_ce_n_o,
    output logic                   ram_oe_n_o,
    output logic                   ram_we_n_o
);
    import soc_bus_pkg::*;

    localparam int unsigned CNT_W = $clog2(ACCESS_CYCLES + 1);
    localparam logic [CNT_W-1:0] LAST_PHASE = CNT_W'(ACCESS_CYCLES - 1);

    logic [CNT_W-1:0] cnt_q;   // phase of the running access
    logic             run_q;   // past the first cycle
    logic [CNT_W-1:0] phase;
    logic             active;
    logic             last;
    logic             we_q;    // held access fields
    ram_addr_t        addr_q;
    word_t            wdata_q;
    mask_t            mask_q;
    logic             we_cur;  // first cycle takes the command directly
    ram_addr_t        addr_cur;
    word_t            wdata_cur;
    mask_t            mask_cur;

    assign phase  = cmd.start ? '0 : cnt_q;
    assign active = cmd.start | run_q;
    assign last   = active & (phase == LAST_PHASE);

    assign we_cur    = cmd.start ? cmd.we : we_q;
    assign addr_cur  = cmd.start ? cmd.addr : addr_q;
    assign wdata_cur = cmd.start ? cmd.wdata : wdata_q;
    assign mask_cur  = cmd.start ? cmd.mask : mask_q;

    always_ff @(posedge clk_cpu or negedge locked_i) begin
        if (!locked_i) begin
            run_q <= 1'b0;
            cnt_q <= '0;
        end else if (cmd.start) begin
            run_q <= 1'b1;
            cnt_q <= CNT_W'(1);
        end else if (run_q) begin
            run_q <= (cnt_q != LAST_PHASE);  // drop after the last cycle
            cnt_q <= (cnt_q == LAST_PHASE) ? '0 : cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (cmd.start) begin
            we_q    <= cmd.we;
            addr_q  <= cmd.addr;
            wdata_q <= cmd.wdata;
            mask_q  <= cmd.mask;
        end
    end

    assign ram_addr_o    = addr_cur;
    assign ram_data_o    = wdata_cur;
    assign ram_data_oe_o = active & we_cur;
    assign ram_be_n_o    = active ? ~mask_cur : '1;
    assign ram_ce_n_o    = ~active;                  // held low whole access
    assign ram_oe_n_o    = ~(active & ~we_cur);
    // write pulse ends one cycle early, last cycle is data hold
    assign ram_we_n_o    = ~(active & we_cur & (phase != LAST_PHASE));

    assign cmd.done  = last;
    assign cmd.rdata = (last & ~we_cur) ? ram_data_i : '0;  // sample in last cycle

endmodule

//--- flist.f
design/soc_bus_pkg.sv
design/bank_port_if.sv
design/sram_cmd_if.sv
design/bus_router.sv
design/bank_sequencer.sv
design/sram_phy.sv
design/soc_bus_top.sv
testbench/sram_model.sv
testbench/soc_bus_checker.sv
testbench/soc_bus_properties.sv
testbench/tb_soc_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the soc bus testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_soc_bus -f flist.f -o sim_tb

# keep going after a failing run so the log is still searched
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
else
    exit 1
fi

//--- testbench/soc_bus_checker.sv
`timescale 1ns/1ps

// compares dut outputs at the falling clock edge
module soc_bus_checker (
    input logic               clk_cpu,
    input logic               locked_i,
    input logic               stall_i,
    input soc_bus_pkg::word_t inst_data_i,
    input soc_bus_pkg::word_t data_rdata_i,
    input logic [6:0]         base_strb_n_i,  // be_n, ce_n, oe_n, we_n
    input logic [6:0]         ext_strb_n_i,
    input logic               base_drv_i,     // dut drives the base data pins
    input logic               ext_drv_i
);
    import soc_bus_pkg::*;

    int    word_errs = 0;
    int    stall_errs = 0;
    int    strobe_errs = 0;
    logic  armed = 1'b0;
    logic  seen_req = 1'b0;
    string name;
    logic  chk_i, chk_d, quiet;
    word_t iexp, dexp;
    int    stall_exp;
    int    stall_cnt;

    // load the expectation for the next row
    task automatic arm(input string n, input logic ci, input word_t ie, input logic cd,
                       input word_t de, input int st);
        name = n;
        chk_i = ci;
        iexp = ie;
        chk_d = cd;
        dexp = de;
        stall_exp = st;
        quiet = (st == 0);  // no bank may be touched
        stall_cnt = 0;
        seen_req = 1'b1;
        armed = 1'b1;
    endtask

    always @(negedge clk_cpu) begin
        if (locked_i && !seen_req && (stall_i || base_drv_i || ext_drv_i
                                      || !(&base_strb_n_i) || !(&ext_strb_n_i))) begin
            strobe_errs++;
            $display("bus not quiet after reset before the first request");
        end
        // data pins driven from both sides
        if ((base_drv_i && !base_strb_n_i[1]) || (ext_drv_i && !ext_strb_n_i[1])) begin
            strobe_errs++;
            $display("dut drives the data pins while the sram output is enabled");
        end
        if (armed) begin
            if (quiet && (!base_strb_n_i[2] || !ext_strb_n_i[2])) begin
                strobe_errs++;
                $display("%s: a chip enable went low on a request that maps nowhere", name);
            end
            if (stall_i) begin
                stall_cnt++;
            end else begin
                armed = 1'b0;  // row released this cycle
                if (stall_cnt != stall_exp) begin
                    stall_errs++;
                    $display("[FAIL] %s stall cycles expected %0d actual %0d", name,
                             stall_exp, stall_cnt);
                end
                if (chk_i && inst_data_i !== iexp) begin
                    word_errs++;
                    $display("[FAIL] %s inst word expected %h actual %h", name, iexp, inst_data_i);
                end
                if (chk_d && data_rdata_i !== dexp) begin
                    word_errs++;
                    $display("[FAIL] %s data word expected %h actual %h", name, dexp,
                             data_rdata_i);
                end
            end
        end
    end

endmodule

//--- testbench/soc_bus_properties.sv
`timescale 1ns/1ps

module soc_bus_properties (
    input logic clk_cpu,
    input logic locked_i,
    input logic stall_i,
    input logic base_ce_n_i,
    input logic base_oe_n_i,
    input logic base_we_n_i,
    input logic ext_ce_n_i,
    input logic ext_oe_n_i,
    input logic ext_we_n_i
);

    int assert_errs = 0;  // failed assertions so far

    // no stall while held in reset
    assert property (@(posedge clk_cpu) !locked_i |-> !stall_i)
        else begin
            assert_errs++;
            $error("stall raised during reset");
        end

    // a strobe never fires without chip enable
    assert property (@(posedge clk_cpu) disable iff (!locked_i)
        (!base_we_n_i || !base_oe_n_i) |-> !base_ce_n_i)
        else begin
            assert_errs++;
            $error("base bank strobe low with chip enable high");
        end

    assert property (@(posedge clk_cpu) disable iff (!locked_i)
        (!ext_we_n_i || !ext_oe_n_i) |-> !ext_ce_n_i)
        else begin
            assert_errs++;
            $error("ext bank strobe low with chip enable high");
        end

endmodule

bind soc_bus_top soc_bus_properties props_i (
    .clk_cpu(clk_cpu), .locked_i(locked_i), .stall_i(stall_o),
    .base_ce_n_i(base_ram_ce_n_o), .base_oe_n_i(base_ram_oe_n_o), .base_we_n_i(base_ram_we_n_o),
    .ext_ce_n_i(ext_ram_ce_n_o), .ext_oe_n_i(ext_ram_oe_n_o), .ext_we_n_i(ext_ram_we_n_o)
);

//--- testbench/sram_model.sv
`timescale 1ns/1ps

// async sram model of one bank with active low byte lanes
module sram_model (
    input  soc_bus_pkg::ram_addr_t addr_i,
    input  soc_bus_pkg::word_t     data_i,    // from the dut data pins
    input  logic                   data_oe_i,
    input  soc_bus_pkg::mask_t     be_n_i,
    input  logic                   ce_n_i,
    input  logic                   oe_n_i,
    input  logic                   we_n_i,
    output soc_bus_pkg::word_t     data_o
);
    import soc_bus_pkg::*;

    word_t mem [0:(1<<20)-1];

    // fill pattern built from the whole word index
    initial begin
        for (int i = 0; i < (1 << 20); i++)
            mem[i] = {~i[11:0], i[19:0]};
    end

    // backdoor preload from the testbench
    task automatic load_word(input ram_addr_t a, input word_t w);
        mem[a] = w;
    endtask

    // write lands at the end of the we pulse
    always @(posedge we_n_i) begin
        if (!ce_n_i && data_oe_i) begin
            for (int k = 0; k < 4; k++)
                if (!be_n_i[k])
                    mem[addr_i][8*k +: 8] = data_i[8*k +: 8];
        end
    end

    assign data_o = (!ce_n_i && !oe_n_i) ? mem[addr_i] : '0;  // floats low when idle

endmodule

//--- testbench/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;
    import soc_bus_pkg::*;

    localparam int N = 2;  // access cycles

    typedef struct packed {
        logic  ire;
        addr_t iaddr;
        logic  dre;
        logic  dwe;
        addr_t daddr;
        word_t wdata;
        mask_t mask;
        word_t iexp;
        word_t dexp;
        int    stall;
    } row_t;

    logic clk_cpu, locked_i, inst_re_i, data_re_i, data_we_i, stall_o;
    addr_t inst_addr_i, data_addr_i;
    word_t inst_data_o, data_wdata_i, data_rdata_o;
    mask_t data_mask_i;
    ram_addr_t base_addr, ext_addr;
    word_t base_to_ram, base_from_ram, ext_to_ram, ext_from_ram;
    logic base_oe, base_ce_n, base_oe_n, base_we_n, ext_oe, ext_ce_n, ext_oe_n, ext_we_n;
    mask_t base_be_n, ext_be_n;

    row_t  rows[$];
    string names[$];
    logic  table_ready = 1'b0;
    logic [15:0] lfsr_q = 16'd32901;
    word_t p0, p1, p2, p3;
    int    limit;
    int    errs;

    // fibonacci lfsr with taps 16 14 13 11 stepped once per bit
    function automatic logic take_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        for (int i = 0; i < 32; i++)
            w = {w[30:0], take_bit()};
        return w;
    endfunction

    // masked lanes take the new byte and the rest keep the old one
    function automatic word_t merge_lanes(input word_t old_w, input word_t new_w, input mask_t m);
        word_t r;
        for (int k = 0; k < 4; k++)
            r[8*k +: 8] = m[k] ? new_w[8*k +: 8] : old_w[8*k +: 8];
        return r;
    endfunction

    task automatic add_row(input string n, input logic ire, input addr_t ia, input logic dre,
                           input logic dwe, input addr_t da, input word_t wd, input mask_t m,
                           input word_t ie, input word_t de, input int st);
        names.push_back(n);
        rows.push_back({ire, ia, dre, dwe, da, wd, m, ie, de, st});
    endtask

    soc_bus_top #(.ACCESS_CYCLES(N)) dut_i (
        .clk_cpu, .locked_i, .inst_re_i, .inst_addr_i, .inst_data_o,
        .data_re_i, .data_we_i, .data_addr_i, .data_wdata_i, .data_mask_i, .data_rdata_o, .stall_o,
        .base_ram_addr_o(base_addr), .base_ram_data_i(base_from_ram),
        .base_ram_data_o(base_to_ram), .base_ram_data_oe_o(base_oe), .base_ram_be_n_o(base_be_n),
        .base_ram_ce_n_o(base_ce_n), .base_ram_oe_n_o(base_oe_n), .base_ram_we_n_o(base_we_n),
        .ext_ram_addr_o(ext_addr), .ext_ram_data_i(ext_from_ram),
        .ext_ram_data_o(ext_to_ram), .ext_ram_data_oe_o(ext_oe), .ext_ram_be_n_o(ext_be_n),
        .ext_ram_ce_n_o(ext_ce_n), .ext_ram_oe_n_o(ext_oe_n), .ext_ram_we_n_o(ext_we_n)
    );

    sram_model base_mem (.addr_i(base_addr), .data_i(base_to_ram), .data_oe_i(base_oe),
        .be_n_i(base_be_n), .ce_n_i(base_ce_n), .oe_n_i(base_oe_n), .we_n_i(base_we_n),
        .data_o(base_from_ram));
    sram_model ext_mem (.addr_i(ext_addr), .data_i(ext_to_ram), .data_oe_i(ext_oe),
        .be_n_i(ext_be_n), .ce_n_i(ext_ce_n), .oe_n_i(ext_oe_n), .we_n_i(ext_we_n),
        .data_o(ext_from_ram));

    soc_bus_checker checker_i (.clk_cpu, .locked_i, .stall_i(stall_o),
        .inst_data_i(inst_data_o), .data_rdata_i(data_rdata_o),
        .base_strb_n_i({base_be_n, base_ce_n, base_oe_n, base_we_n}),
        .ext_strb_n_i({ext_be_n, ext_ce_n, ext_oe_n, ext_we_n}),
        .base_drv_i(base_oe), .ext_drv_i(ext_oe));

    initial begin
        clk_cpu = 1'b0;
        forever #10 clk_cpu = ~clk_cpu;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        limit = rows.size() * (2 * N + 4) + 16;
        repeat (limit) @(posedge clk_cpu);
        $display("timeout: run still going after %0d cycles", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        {locked_i, inst_re_i, data_re_i, data_we_i} = '0;
        {inst_addr_i, data_addr_i, data_wdata_i, data_mask_i} = '0;
        @(posedge clk_cpu);  // model fill done by now
        p0 = rand_word();
        p1 = rand_word();
        p2 = rand_word();
        p3 = rand_word();
        base_mem.load_word(20'h40, p0);
        base_mem.load_word(20'h80, p1);
        ext_mem.load_word(20'hc0, p2);
        ext_mem.load_word(20'h100, p3);
        add_row("idle_after_reset", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row("base_write_full", 0, 0, 0, 1, 32'h8000_0010, 32'h1122_3344, FULL_MASK, 0, 0, N);
        add_row("base_read_back", 0, 0, 1, 0, 32'h8000_0010, 0, 0, 0, 32'h1122_3344, N);
        add_row("ext_write_full", 0, 0, 0, 1, 32'h8040_0020, 32'hcafe_f00d, FULL_MASK, 0, 0, N);
        add_row("ext_read_back", 0, 0, 1, 0, 32'h8040_0020, 0, 0, 0, 32'hcafe_f00d, N);
        add_row("partial_write", 0, 0, 0, 1, 32'h8000_0100, 32'haabb_ccdd, 4'b0101, 0, 0, N);
        add_row("partial_read", 0, 0, 1, 0, 32'h8000_0100, 0, 0, 0,
                merge_lanes(p0, 32'haabb_ccdd, 4'b0101), N);
        add_row("split_banks", 1, 32'h8000_0200, 1, 0, 32'h8040_0300, 0, 0, p1, p2, N);
        add_row("same_bank_ext", 1, 32'h8040_0400, 1, 0, 32'h8040_0020, 0, 0, p3,
                32'hcafe_f00d, 2 * N);
        add_row("unmapped_read", 0, 0, 1, 0, 32'h0000_1000, 0, 0, 0, 0, 0);
        add_row("same_bank_base", 1, 32'h8000_0010, 1, 0, 32'h8000_0200, 0, 0, 32'h1122_3344,
                p1, 2 * N);
        table_ready = 1'b1;
        repeat (15) @(posedge clk_cpu);
        #2 locked_i = 1'b1;
        repeat (3) @(posedge clk_cpu);
        foreach (rows[i]) begin
            #2;
            checker_i.arm(names[i], rows[i].ire, rows[i].iexp, rows[i].dre, rows[i].dexp,
                          rows[i].stall);
            inst_re_i = rows[i].ire;
            inst_addr_i = rows[i].iaddr;
            data_re_i = rows[i].dre;
            data_we_i = rows[i].dwe;
            data_addr_i = rows[i].daddr;
            data_wdata_i = rows[i].wdata;
            data_mask_i = rows[i].mask;
            do @(negedge clk_cpu); while (stall_o);  // held until the stall drops
            @(posedge clk_cpu);
        end
        #2 {inst_re_i, data_re_i, data_we_i} = '0;
        repeat (3) @(posedge clk_cpu);
        errs = checker_i.word_errs + checker_i.stall_errs + checker_i.strobe_errs
               + dut_i.props_i.assert_errs;
        $display("errors: words %0d, stall %0d, strobes %0d, assertions %0d",
                 checker_i.word_errs, checker_i.stall_errs, checker_i.strobe_errs,
                 dut_i.props_i.assert_errs);
        if (errs == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
